//--- logic/audioCfgPkg.sv
/*
 * Audio engine configuration types: CPU register port and per-voice settings
 */
package audioCfgPkg;

    localparam int unsigned MAX_VOICES = 8;

    typedef logic [2:0] voiceIdxT;

    typedef enum logic {
        REG_ADDR = 1'b0,    // Start byte address
        REG_CTRL = 1'b1
    } regSelE;

    typedef struct packed {
        logic        play;
        logic        mono;
        logic        right;     // Only looked at when not mono
        logic        loop;
        logic [11:0] reserved;
        logic [15:0] count;
    } voiceCtrlT;

    // Same word, decoded by regSelE
    typedef union packed {
        logic [31:0] addr;
        voiceCtrlT   ctrl;
    } regWordU;

    typedef struct packed {
        logic     strobe;
        voiceIdxT voice;
        regSelE   sel;
        regWordU  word;
    } regWriteT;

    typedef struct packed {
        logic [MAX_VOICES-1:0] mono;
        logic [MAX_VOICES-1:0] right;
    } voiceRouteT;

endpackage

//--- logic/audioStreamPkg.sv
/*
 * Sample data in flight: AXI-Lite read request/response, voice frame, stereo pair
 */
package audioStreamPkg;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    typedef logic signed [15:0] sampleT;

    // One sample per voice, unused voices read as zero
    typedef struct packed {
        sampleT [audioCfgPkg::MAX_VOICES-1:0] voice;
    } frameT;

    typedef struct packed {
        sampleT left;
        sampleT right;
    } stereoT;

    typedef struct packed {
        logic        arValid;
        logic [31:0] arAddr;
    } axiRdReqT;

    typedef struct packed {
        logic        rValid;
        logic [15:0] rData;     // Big-endian in memory
        logic [1:0]  rResp;
    } axiRdRspT;

endpackage

//--- logic/voiceRegisters.sv
/*
 * Voice register file: start address, current address, remaining count and routing
 * per voice, stepped forward by the fetcher
 */
`timescale 1ns/1ps

module voiceRegisters #(
    parameter int unsigned NUM_VOICES = 8
) (
    input  logic                        i_aclk,
    input  logic                        i_aresetn,
    input  audioCfgPkg::regWriteT       i_regWrite,
    input  logic                        i_advance,
    input  audioCfgPkg::voiceIdxT       i_advanceVoice,
    output logic [NUM_VOICES-1:0]       o_playing,
    output logic [NUM_VOICES-1:0][31:0] o_voiceAddr,
    output audioCfgPkg::voiceRouteT     o_route
);
    import audioCfgPkg::*;

    logic [NUM_VOICES-1:0][31:0] startAddr;
    logic [NUM_VOICES-1:0][15:0] sampleCount;
    logic [NUM_VOICES-1:0][15:0] remaining;
    logic [NUM_VOICES-1:0]       mono;
    logic [NUM_VOICES-1:0]       right;
    logic [NUM_VOICES-1:0]       loop;
    logic [NUM_VOICES-1:0]       addrWrite;
    logic [NUM_VOICES-1:0]       ctrlWrite;
    logic [NUM_VOICES-1:0]       advance;
    logic [NUM_VOICES-1:0]       lastSample;

    always_comb begin
        for (int v = 0; v < NUM_VOICES; v++) begin
            addrWrite[v]  = i_regWrite.strobe && i_regWrite.voice == voiceIdxT'(v)
                            && i_regWrite.sel == REG_ADDR;
            ctrlWrite[v]  = i_regWrite.strobe && i_regWrite.voice == voiceIdxT'(v)
                            && i_regWrite.sel == REG_CTRL;
            advance[v]    = i_advance && i_advanceVoice == voiceIdxT'(v) && o_playing[v];
            lastSample[v] = remaining[v] <= 16'd1;
        end
    end

    always_ff @(posedge i_aclk) begin
        if (!i_aresetn) begin
            o_playing <= '0;
            mono      <= '0;
            right     <= '0;
            loop      <= '0;
        end else begin
            for (int v = 0; v < NUM_VOICES; v++) begin
                if (ctrlWrite[v]) begin  // CPU write wins over a same-cycle advance
                    o_playing[v] <= i_regWrite.word.ctrl.play;
                    mono[v]      <= i_regWrite.word.ctrl.mono;
                    right[v]     <= i_regWrite.word.ctrl.right;
                    loop[v]      <= i_regWrite.word.ctrl.loop;
                end else if (advance[v] && lastSample[v] && !loop[v]) begin
                    o_playing[v] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge i_aclk) begin
        for (int v = 0; v < NUM_VOICES; v++) begin
            if (addrWrite[v])
                startAddr[v] <= i_regWrite.word.addr;
            if (ctrlWrite[v]) begin
                sampleCount[v] <= i_regWrite.word.ctrl.count;
                if (i_regWrite.word.ctrl.play) begin
                    remaining[v]   <= i_regWrite.word.ctrl.count;
                    o_voiceAddr[v] <= startAddr[v];
                end
            end else if (advance[v]) begin
                if (lastSample[v]) begin  // Rewind, harmless when stopping
                    remaining[v]   <= sampleCount[v];
                    o_voiceAddr[v] <= startAddr[v];
                end else begin
                    remaining[v]   <= remaining[v] - 16'd1;
                    o_voiceAddr[v] <= o_voiceAddr[v] + 32'd2;
                end
            end
        end
    end

    always_comb begin
        o_route = '0;
        o_route.mono[NUM_VOICES-1:0]  = mono;
        o_route.right[NUM_VOICES-1:0] = right;
    end

    // Fetcher only steps voices that were playing when their sample was read
    advanceLive: assert property (@(posedge i_aclk) disable iff (!i_aresetn)
        i_advance |-> i_advanceVoice < NUM_VOICES && o_playing[i_advanceVoice]);

endmodule

//--- logic/sampleFetcher.sv
/*
 * AXI-Lite read master: fetches one sample per playing voice each frame and
 * hands the frame to the mixer over a four-phase req/ack
 */
`timescale 1ns/1ps

module sampleFetcher #(
    parameter int unsigned NUM_VOICES = 8
) (
    input  logic                        i_aclk,
    input  logic                        i_aresetn,
    input  logic                        i_frameTick,
    input  logic [NUM_VOICES-1:0]       i_playing,
    input  logic [NUM_VOICES-1:0][31:0] i_voiceAddr,
    output logic                        o_advance,
    output audioCfgPkg::voiceIdxT       o_advanceVoice,
    output audioStreamPkg::axiRdReqT    o_axiReq,
    input  logic                        i_arReady,
    input  audioStreamPkg::axiRdRspT    i_axiRsp,
    output logic                        o_rReady,
    output logic                        o_frameReq,
    output audioStreamPkg::frameT       o_frame,
    input  logic                        i_frameAck
);
    import audioCfgPkg::*;
    import audioStreamPkg::*;

    typedef enum logic [2:0] {IDLE, ADDR, DATA, HANDOFF, RELEASE} stateE;

    localparam voiceIdxT LAST_VOICE = voiceIdxT'(NUM_VOICES - 1);

    stateE                   state;
    voiceIdxT                voiceIdx;
    logic [NUM_VOICES-1:0]   fetched;  // Voices read over AXI this frame
    sampleT [NUM_VOICES-1:0] samples;
    logic                    arValid;
    logic [31:0]             arAddr;
    logic                    lastVoice;
    logic                    skipVoice;
    logic                    issueAddr;
    logic                    addrDone;
    logic                    dataDone;

    assign lastVoice = voiceIdx == LAST_VOICE;
    assign skipVoice = state == ADDR && !arValid && !i_playing[voiceIdx];
    assign issueAddr = state == ADDR && !arValid && i_playing[voiceIdx];
    assign addrDone  = arValid && i_arReady;
    assign dataDone  = state == DATA && o_rReady && i_axiRsp.rValid;

    always_ff @(posedge i_aclk) begin
        if (!i_aresetn) begin
            state      <= IDLE;
            voiceIdx   <= '0;
            fetched    <= '0;
            arValid    <= 1'b0;
            o_rReady   <= 1'b0;
            o_frameReq <= 1'b0;
            o_advance  <= 1'b0;
        end else begin
            o_advance <= 1'b0;
            case (state)
                IDLE: begin
                    if (i_frameTick) begin  // Ticks while busy are dropped
                        state    <= ADDR;
                        voiceIdx <= '0;
                        fetched  <= '0;
                    end
                end
                ADDR: begin
                    if (issueAddr)
                        arValid <= 1'b1;
                    if (addrDone) begin
                        arValid  <= 1'b0;
                        o_rReady <= 1'b1;
                        state    <= DATA;
                    end
                end
                DATA: begin
                    if (dataDone) begin
                        o_rReady          <= 1'b0;
                        fetched[voiceIdx] <= 1'b1;
                    end
                end
                HANDOFF: begin
                    if (i_frameAck) begin
                        o_frameReq <= 1'b0;
                        voiceIdx   <= '0;
                        state      <= RELEASE;
                    end
                end
                RELEASE: begin
                    // Step voices only now, so the mixer sees them still playing
                    o_advance         <= fetched[voiceIdx] && i_playing[voiceIdx];
                    fetched[voiceIdx] <= 1'b0;
                    if (!lastVoice)
                        voiceIdx <= voiceIdx + voiceIdxT'(1);
                    else if (!i_frameAck)
                        state <= IDLE;
                end
                default: state <= IDLE;
            endcase

            if (skipVoice || dataDone) begin
                if (lastVoice) begin
                    o_frameReq <= 1'b1;
                    state      <= HANDOFF;
                end else begin
                    voiceIdx <= voiceIdx + voiceIdxT'(1);
                    state    <= ADDR;
                end
            end
        end
    end

    always_ff @(posedge i_aclk) begin
        if (issueAddr)
            arAddr <= i_voiceAddr[voiceIdx];
        if (skipVoice)
            samples[voiceIdx] <= '0;
        if (dataDone)  // Byte swap, error reads as silence
            samples[voiceIdx] <= i_axiRsp.rResp == RESP_OKAY
                                 ? {i_axiRsp.rData[7:0], i_axiRsp.rData[15:8]} : '0;
        if (state == RELEASE)
            o_advanceVoice <= voiceIdx;
    end

    always_comb begin
        o_axiReq.arValid = arValid;
        o_axiReq.arAddr  = arAddr;
        o_frame          = '0;
        for (int v = 0; v < NUM_VOICES; v++)
            o_frame.voice[v] = samples[v];
    end

    arAddrHold: assert property (@(posedge i_aclk) disable iff (!i_aresetn)
        arValid && !i_arReady |=> arValid && $stable(arAddr));

    reqUntilAck: assert property (@(posedge i_aclk) disable iff (!i_aresetn)
        o_frameReq && !i_frameAck |=> o_frameReq);

endmodule

//--- logic/stereoMixer.sv
/*
 * Stereo mixer: routes each voice left, right or both, sums with saturation
 */
`timescale 1ns/1ps

module stereoMixer #(
    parameter int unsigned NUM_VOICES = 8
) (
    input  logic                    i_aclk,
    input  logic                    i_aresetn,
    input  logic                    i_frameReq,
    input  audioStreamPkg::frameT   i_frame,
    input  logic [NUM_VOICES-1:0]   i_playing,
    input  audioCfgPkg::voiceRouteT i_route,
    output logic                    o_frameAck,
    output audioStreamPkg::stereoT  o_mix
);
    import audioStreamPkg::*;

    localparam int SUM_W = 20;  // Headroom for eight full-scale voices

    logic signed [SUM_W-1:0] leftSum;
    logic signed [SUM_W-1:0] rightSum;
    logic signed [SUM_W-1:0] extSample;
    logic                    capture;

    function automatic sampleT saturate(input logic signed [SUM_W-1:0] sum);
        if (sum > 32767)
            return 16'sh7fff;
        if (sum < -32768)
            return 16'sh8000;
        return sampleT'(sum[15:0]);
    endfunction

    always_comb begin
        leftSum   = '0;
        rightSum  = '0;
        extSample = '0;
        for (int v = 0; v < NUM_VOICES; v++) begin
            extSample = {{(SUM_W-16){i_frame.voice[v][15]}}, i_frame.voice[v]};
            if (i_playing[v] && (i_route.mono[v] || !i_route.right[v]))
                leftSum = leftSum + extSample;
            if (i_playing[v] && (i_route.mono[v] || i_route.right[v]))
                rightSum = rightSum + extSample;
        end
    end

    assign capture = i_frameReq && !o_frameAck;

    always_ff @(posedge i_aclk) begin
        if (!i_aresetn) begin
            o_frameAck <= 1'b0;
            o_mix      <= '0;
        end else if (capture) begin
            o_frameAck  <= 1'b1;
            o_mix.left  <= saturate(leftSum);
            o_mix.right <= saturate(rightSum);
        end else if (!i_frameReq) begin
            o_frameAck <= 1'b0;  // Fourth phase
        end
    end

endmodule

//--- logic/i2sSerializer.sv
/*
 * I2S transmitter: divided bit clock, word select and MSB-first data,
 * Philips timing with one bit of delay after word select
 */
`timescale 1ns/1ps

module i2sSerializer #(
    parameter int unsigned BCLK_DIV = 4
) (
    input  logic                   i_aclk,
    input  logic                   i_aresetn,
    input  audioStreamPkg::stereoT i_mix,
    output logic                   o_frameTick,
    output logic                   o_bclk,
    output logic                   o_lrclk,
    output logic                   o_dout
);
    localparam int DIV_W        = $clog2(BCLK_DIV);
    localparam int FRAME_CYCLES = 64 * BCLK_DIV;

    logic [DIV_W-1:0] divCnt;
    logic [4:0]       bitCnt;   // Slot within the frame
    logic [4:0]       nextBit;
    logic             halfTick;
    logic             fallEdge;
    logic [31:0]      shiftReg;

    assign halfTick = divCnt == DIV_W'(BCLK_DIV - 1);
    assign fallEdge = halfTick && o_bclk;
    assign nextBit  = bitCnt + 5'd1;

    always_ff @(posedge i_aclk) begin
        if (!i_aresetn) begin
            divCnt      <= '0;
            bitCnt      <= 5'd31;  // First falling edge starts a frame
            o_bclk      <= 1'b0;
            o_lrclk     <= 1'b0;
            o_dout      <= 1'b0;
            o_frameTick <= 1'b0;
            shiftReg    <= '0;
        end else begin
            o_frameTick <= fallEdge && nextBit == 5'd0;
            divCnt      <= halfTick ? '0 : divCnt + DIV_W'(1);
            if (halfTick)
                o_bclk <= ~o_bclk;
            if (fallEdge) begin
                bitCnt  <= nextBit;
                o_lrclk <= nextBit[4];     // Low for left
                o_dout  <= shiftReg[31];   // Lags word select by one bit
                if (nextBit == 5'd0)
                    shiftReg <= {i_mix.left, i_mix.right};
                else
                    shiftReg <= {shiftReg[30:0], 1'b0};
            end
        end
    end

    // One tick per 32 bit periods
    tickPeriod: assert property (@(posedge i_aclk) disable iff (!i_aresetn)
        o_frameTick |=> !o_frameTick [*FRAME_CYCLES-1] ##1 o_frameTick);

endmodule

//--- logic/audioSubsystem.sv
/*
 * Sample playback engine top: voice registers, AXI-Lite fetcher, mixer, I2S output
 */
`timescale 1ns/1ps

module audioSubsystem #(
    parameter int unsigned NUM_VOICES = 8,
    parameter int unsigned BCLK_DIV   = 4
) (
    input  logic                  i_aclk,
    input  logic                  i_aresetn,
    input  audioCfgPkg::regWriteT i_regWrite,
    output logic [31:0]           o_awAddr,
    output logic [2:0]            o_awProt,
    output logic                  o_awValid,
    output logic [15:0]           o_wData,
    output logic [1:0]            o_wStrb,
    output logic                  o_wValid,
    output logic                  o_bReady,
    output logic [31:0]           o_arAddr,
    output logic [2:0]            o_arProt,
    output logic                  o_arValid,
    input  logic                  i_arReady,
    input  logic [15:0]           i_rData,
    input  logic [1:0]            i_rResp,
    input  logic                  i_rValid,
    output logic                  o_rReady,
    output logic                  o_bclk,
    output logic                  o_lrclk,
    output logic                  o_dout
);
    import audioCfgPkg::*;
    import audioStreamPkg::*;

    logic [NUM_VOICES-1:0]       playing;
    logic [NUM_VOICES-1:0][31:0] voiceAddr;
    logic                        advance;
    voiceIdxT                    advanceVoice;
    voiceRouteT                  route;
    axiRdReqT                    axiReq;
    axiRdRspT                    axiRsp;
    logic                        frameReq;
    logic                        frameAck;
    frameT                       frame;
    stereoT                      mix;
    logic                        frameTick;

    // Read-only master
    assign o_awAddr  = '0;
    assign o_awProt  = '0;
    assign o_awValid = 1'b0;
    assign o_wData   = '0;
    assign o_wStrb   = '0;
    assign o_wValid  = 1'b0;
    assign o_bReady  = 1'b0;

    assign o_arAddr  = axiReq.arAddr;
    assign o_arValid = axiReq.arValid;
    assign o_arProt  = '0;
    assign axiRsp    = '{rValid: i_rValid, rData: i_rData, rResp: i_rResp};

    voiceRegisters #(.NUM_VOICES(NUM_VOICES)) voiceRegs (
        .i_aclk(i_aclk), .i_aresetn(i_aresetn), .i_regWrite(i_regWrite),
        .i_advance(advance), .i_advanceVoice(advanceVoice),
        .o_playing(playing), .o_voiceAddr(voiceAddr), .o_route(route)
    );

    sampleFetcher #(.NUM_VOICES(NUM_VOICES)) fetcher (
        .i_aclk(i_aclk), .i_aresetn(i_aresetn), .i_frameTick(frameTick),
        .i_playing(playing), .i_voiceAddr(voiceAddr),
        .o_advance(advance), .o_advanceVoice(advanceVoice),
        .o_axiReq(axiReq), .i_arReady(i_arReady), .i_axiRsp(axiRsp), .o_rReady(o_rReady),
        .o_frameReq(frameReq), .o_frame(frame), .i_frameAck(frameAck)
    );

    stereoMixer #(.NUM_VOICES(NUM_VOICES)) mixer (
        .i_aclk(i_aclk), .i_aresetn(i_aresetn), .i_frameReq(frameReq), .i_frame(frame),
        .i_playing(playing), .i_route(route), .o_frameAck(frameAck), .o_mix(mix)
    );

    i2sSerializer #(.BCLK_DIV(BCLK_DIV)) serializer (
        .i_aclk(i_aclk), .i_aresetn(i_aresetn), .i_mix(mix), .o_frameTick(frameTick),
        .o_bclk(o_bclk), .o_lrclk(o_lrclk), .o_dout(o_dout)
    );

endmodule

//--- testbench/axiSampleMemory.sv
/*
 * AXI-Lite read slave for the testbench: the sample is a function of the address,
 * stored big-endian, with ready and valid delays set from outside
 */
`timescale 1ns/1ps

module axiSampleMemory (
    input  logic        i_aclk,
    input  logic        i_aresetn,
    input  logic [31:0] i_arAddr,
    input  logic        i_arValid,
    output logic        o_arReady,
    output logic [15:0] o_rData,
    output logic [1:0]  o_rResp,
    output logic        o_rValid,
    input  logic        i_rReady,
    input  logic [1:0]  i_arDelay,
    input  logic [1:0]  i_rDelay
);
    logic        readPhase;
    logic [1:0]  delayCnt;
    logic [31:0] addr;
    logic [15:0] value;

    assign value   = addr[16:1] ^ addr[31:16];
    assign o_rResp = 2'b00;

    always_ff @(posedge i_aclk) begin
        if (!i_aresetn) begin
            readPhase <= 1'b0;
            delayCnt  <= '0;
            o_arReady <= 1'b0;
            o_rValid  <= 1'b0;
            o_rData   <= '0;
        end else if (!readPhase) begin
            if (o_arReady && i_arValid) begin
                o_arReady <= 1'b0;
                addr      <= i_arAddr;
                delayCnt  <= i_rDelay;
                readPhase <= 1'b1;
            end else if (i_arValid && !o_arReady) begin
                if (delayCnt == 2'd0)
                    o_arReady <= 1'b1;
                else
                    delayCnt <= delayCnt - 2'd1;
            end
        end else begin
            if (o_rValid && i_rReady) begin
                o_rValid  <= 1'b0;
                delayCnt  <= i_arDelay;
                readPhase <= 1'b0;
            end else if (!o_rValid) begin
                if (delayCnt == 2'd0) begin
                    o_rValid <= 1'b1;
                    o_rData  <= {value[7:0], value[15:8]};  // Big-endian bytes
                end else begin
                    delayCnt <= delayCnt - 2'd1;
                end
            end
        end
    end

endmodule

//--- testbench/audioSubsystemTb.sv
/*
 * Testbench for the playback engine: programs voices, decodes I2S and checks
 * each frame against a mix model
 */
`timescale 1ns/1ps

module audioSubsystemTb;
    import audioCfgPkg::*;
    import audioStreamPkg::*;

    localparam int WAIT_LIMIT = 2000;

    logic        aclk;
    logic        aresetn;
    regWriteT    regWrite;
    logic [31:0] arAddr;
    logic        arValid, arReady, rValid, rReady;
    logic [15:0] rData;
    logic [1:0]  rResp;
    logic [31:0] awAddr;
    logic [2:0]  awProt, arProt;
    logic        awValid, wValid, bReady;
    logic [15:0] wData;
    logic [1:0]  wStrb;
    logic        bclk, lrclk, dout;
    logic [1:0]  arDelay, rDelay;
    logic        randomDelays;
    logic [31:0] lfsrState = 32'hf8a4;
    logic [15:0] randWord;

    // Voice model
    logic [31:0] mStart [8];
    logic [31:0] mAddr [8];
    logic [15:0] mCount [8];
    logic [15:0] mRemain [8];
    logic [7:0]  mPlaying, mMono, mRight, mLoop;
    stereoT      expQ [$];

    logic        bclkPrev, lrPrev, decValid, wsToggle, wsSeen;
    logic [31:0] shiftIn, decWord;
    stereoT      decExp;
    int          wsBits, wsBitsAtToggle;
    int          decodedFrames = 0;
    int          leftErrors = 0, rightErrors = 0, wsErrors = 0, tieErrors = 0;
    int          testsRun = 0, testsFailed = 0;

    audioSubsystem dut (
        .i_aclk(aclk), .i_aresetn(aresetn), .i_regWrite(regWrite),
        .o_awAddr(awAddr), .o_awProt(awProt), .o_awValid(awValid), .o_wData(wData),
        .o_wStrb(wStrb), .o_wValid(wValid), .o_bReady(bReady), .o_arAddr(arAddr),
        .o_arProt(arProt), .o_arValid(arValid),
        .i_arReady(arReady), .i_rData(rData), .i_rResp(rResp), .i_rValid(rValid),
        .o_rReady(rReady), .o_bclk(bclk), .o_lrclk(lrclk), .o_dout(dout)
    );

    axiSampleMemory memory (
        .i_aclk(aclk), .i_aresetn(aresetn), .i_arAddr(arAddr), .i_arValid(arValid),
        .o_arReady(arReady), .o_rData(rData), .o_rResp(rResp), .o_rValid(rValid),
        .i_rReady(rReady), .i_arDelay(arDelay), .i_rDelay(rDelay)
    );

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32, 22, 2, 1
    endfunction

    function automatic int sampleAt(input logic [31:0] a);
        logic [15:0] w;
        w = a[16:1] ^ a[31:16];
        return int'($signed(w));
    endfunction

    function automatic sampleT clampToWord(input int sum);
        if (sum > 32767)
            return 16'sh7fff;
        if (sum < -32768)
            return 16'sh8000;
        return sampleT'(sum);
    endfunction

    function automatic int errorTotal();
        return leftErrors + rightErrors + wsErrors + tieErrors;
    endfunction

    // One bit per LFSR step
    always @(negedge aclk) begin
        logic [19:0] bits;
        for (int i = 0; i < 20; i++) begin
            lfsrState = lfsrStep(lfsrState);
            bits[i]   = lfsrState[0];
        end
        arDelay  <= randomDelays ? bits[1:0] : 2'd0;
        rDelay   <= randomDelays ? bits[3:2] : 2'd0;
        randWord <= bits[19:4];
    end

    task automatic modelFetch(output stereoT res);
        int left, right, s;
        left  = 0;
        right = 0;
        for (int v = 0; v < 8; v++) begin
            if (mPlaying[v]) begin
                s = sampleAt(mAddr[v]);
                if (mMono[v] || !mRight[v])
                    left += s;
                if (mMono[v] || mRight[v])
                    right += s;
                if (mRemain[v] <= 16'd1) begin
                    mAddr[v]   = mStart[v];
                    mRemain[v] = mCount[v];
                    if (!mLoop[v])
                        mPlaying[v] = 1'b0;
                end else begin
                    mRemain[v] = mRemain[v] - 16'd1;
                    mAddr[v]   = mAddr[v] + 32'd2;
                end
            end
        end
        res.left  = clampToWord(left);
        res.right = clampToWord(right);
    endtask

    // Model update, I2S decode and word-select timing
    always @(posedge aclk) begin
        stereoT nextMix;
        if (!aresetn) begin
            mPlaying = '0;
            mMono    = '0;
            mRight   = '0;
            mLoop    = '0;
            expQ.delete();
            expQ.push_back('0);  // Frame 0 carries the reset mix
            bclkPrev <= 1'b0;
            lrPrev   <= 1'b0;
            shiftIn  <= '0;
            decValid <= 1'b0;
            wsToggle <= 1'b0;
            wsSeen   <= 1'b0;
            wsBits   <= 0;
        end else begin
            decValid <= 1'b0;
            wsToggle <= 1'b0;
            bclkPrev <= bclk;
            if (regWrite.strobe) begin
                if (regWrite.sel == REG_ADDR) begin
                    mStart[regWrite.voice] = regWrite.word.addr;
                end else begin
                    mPlaying[regWrite.voice] = regWrite.word.ctrl.play;
                    mMono[regWrite.voice]    = regWrite.word.ctrl.mono;
                    mRight[regWrite.voice]   = regWrite.word.ctrl.right;
                    mLoop[regWrite.voice]    = regWrite.word.ctrl.loop;
                    mCount[regWrite.voice]   = regWrite.word.ctrl.count;
                    if (regWrite.word.ctrl.play) begin
                        mRemain[regWrite.voice] = regWrite.word.ctrl.count;
                        mAddr[regWrite.voice]   = mStart[regWrite.voice];
                    end
                end
            end
            if (dut.frameTick) begin
                modelFetch(nextMix);
                expQ.push_back(nextMix);
            end
            if (bclk && !bclkPrev) begin
                shiftIn <= {shiftIn[30:0], dout};
                lrPrev  <= lrclk;
                if (lrclk != lrPrev) begin
                    wsToggle       <= wsSeen;
                    wsBitsAtToggle <= wsBits;
                    wsBits         <= 1;
                    wsSeen         <= 1'b1;
                end else begin
                    wsBits <= wsBits + 1;
                end
                if (!lrclk && lrPrev) begin  // Right LSB arrives after the new frame starts
                    decWord  <= {shiftIn[30:0], dout};
                    decExp   <= expQ.pop_front();
                    decValid <= 1'b1;
                    decodedFrames <= decodedFrames + 1;
                end
            end
        end
    end

    leftMatch: assert property (@(posedge aclk) disable iff (!aresetn)
        decValid |-> decWord[31:16] == decExp.left)
    else begin
        leftErrors++;
        $display("Mismatch at %0t: left word got %0d expected %0d", $time,
                 $signed(decWord[31:16]), decExp.left);
    end

    rightMatch: assert property (@(posedge aclk) disable iff (!aresetn)
        decValid |-> decWord[15:0] == decExp.right)
    else begin
        rightErrors++;
        $display("Mismatch at %0t: right word got %0d expected %0d", $time,
                 $signed(decWord[15:0]), decExp.right);
    end

    wsPeriod: assert property (@(posedge aclk) disable iff (!aresetn)
        wsToggle |-> wsBitsAtToggle == 16)
    else begin
        wsErrors++;
        $display("Mismatch at %0t: lrclk half period got %0d expected 16", $time,
                 wsBitsAtToggle);
    end

    // Read-only master keeps the write channel and arprot at zero
    tieOffs: assert property (@(posedge aclk) disable iff (!aresetn)
        {awAddr, awProt, awValid, wData, wStrb, wValid, bReady, arProt} == '0)
    else begin
        tieErrors++;
        $display("Mismatch at %0t: AXI tie-offs got %h expected 0", $time,
                 {awAddr, awProt, awValid, wData, wStrb, wValid, bReady, arProt});
    end

    task automatic waitWordSelect(input logic level);
        int cycles;
        cycles = 0;
        while (lrclk !== level && cycles < WAIT_LIMIT) begin
            @(negedge aclk);
            cycles++;
        end
        if (lrclk !== level) begin
            $display("Timeout: word select did not reach %0d in %0d cycles", level, WAIT_LIMIT);
            $display("Simulation finished: FAIL");
            $finish;
        end
    endtask

    // Ends just after word select rises, while the fetcher is idle
    task automatic waitFrames(input int n);
        for (int i = 0; i < n; i++) begin
            waitWordSelect(1'b0);
            waitWordSelect(1'b1);
        end
    endtask

    task automatic writeReg(input int v, input regSelE sel, input logic [31:0] word);
        @(negedge aclk);
        regWrite.strobe    = 1'b1;
        regWrite.voice     = voiceIdxT'(v);
        regWrite.sel       = sel;
        regWrite.word.addr = word;
        @(negedge aclk);
        regWrite.strobe = 1'b0;
    endtask

    task automatic programVoice(input int v, input logic [31:0] start, input logic [15:0] count,
                                input logic mono, input logic right, input logic loop);
        voiceCtrlT ctrl;
        ctrl       = '0;
        ctrl.play  = 1'b1;
        ctrl.mono  = mono;
        ctrl.right = right;
        ctrl.loop  = loop;
        ctrl.count = count;
        writeReg(v, REG_ADDR, start);
        writeReg(v, REG_CTRL, ctrl);
    endtask

    task automatic randomValue(output logic [15:0] value);
        @(posedge aclk);
        value = randWord;
    endtask

    // Stop everything and let the checks of the last frames run out
    task automatic finishTest(input string name, input int startErrors);
        for (int v = 0; v < 8; v++)
            writeReg(v, REG_CTRL, 32'h0);
        waitFrames(3);
        testsRun++;
        if (errorTotal() != startErrors)
            testsFailed++;
        $display("%s: %s", name, errorTotal() == startErrors ? "ok" : "FAILED");
    endtask

    initial begin
        int          startErrors;
        logic [15:0] r [8];
        aresetn      = 1'b0;
        regWrite     = '0;
        randomDelays = 1'b0;
        repeat (8) @(negedge aclk);
        aresetn = 1'b1;

        startErrors = errorTotal();
        waitFrames(4);
        finishTest("idle after reset", startErrors);

        startErrors = errorTotal();
        randomValue(r[0]);
        waitFrames(1);
        programVoice(0, {15'd0, r[0], 1'b0}, 16'd40, 1'b1, 1'b0, 1'b0);
        waitFrames(6);
        finishTest("single mono voice", startErrors);

        startErrors = errorTotal();
        randomValue(r[0]);
        randomValue(r[1]);
        waitFrames(1);
        programVoice(1, {15'd0, r[0], 1'b0}, 16'd30, 1'b0, 1'b0, 1'b0);
        programVoice(2, {15'd0, r[1], 1'b0}, 16'd30, 1'b0, 1'b1, 1'b0);
        waitFrames(6);
        finishTest("left and right routing", startErrors);

        startErrors = errorTotal();
        for (int v = 0; v < 8; v++)
            programVoice(v, 32'h0000_fff0, 16'd4, 1'b1, 1'b0, 1'b1);
        waitFrames(4);
        for (int v = 0; v < 8; v++)
            programVoice(v, 32'h0001_0000, 16'd4, 1'b1, 1'b0, 1'b1);
        waitFrames(4);
        finishTest("saturation", startErrors);

        startErrors = errorTotal();
        programVoice(3, 32'h0000_1200, 16'd3, 1'b1, 1'b0, 1'b0);
        programVoice(4, 32'h0000_3400, 16'd2, 1'b0, 1'b0, 1'b1);
        waitFrames(8);
        finishTest("stop and loop", startErrors);

        startErrors = errorTotal();
        randomDelays = 1'b1;
        for (int v = 0; v < 8; v++)
            randomValue(r[v]);
        waitFrames(1);
        for (int v = 0; v < 8; v++)
            programVoice(v, {15'd0, r[v], 1'b0}, 16'd5, r[v][3], r[v][7], 1'b1);
        waitFrames(8);
        randomDelays = 1'b0;
        finishTest("random AXI delays", startErrors);

        $display("Tests: %0d run, %0d failed; %0d frames decoded, %0d errors",
                 testsRun, testsFailed, decodedFrames, errorTotal());
        if (errorTotal() == 0 && decodedFrames > 30) begin
            $display("Simulation finished: PASS");
        end else begin
            if (decodedFrames <= 30)
                $display("Too few I2S frames were decoded to trust the checks");
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- audioSubsystem.f
logic/audioCfgPkg.sv
logic/audioStreamPkg.sv
logic/voiceRegisters.sv
logic/sampleFetcher.sv
logic/stereoMixer.sv
logic/i2sSerializer.sv
logic/audioSubsystem.sv
testbench/axiSampleMemory.sv
testbench/audioSubsystemTb.sv

//--- run.sh
#!/bin/sh
# Build and run the playback engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module audioSubsystemTb -f audioSubsystem.f -o audioSim

./obj_dir/audioSim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
grep -q "Simulation finished: PASS" sim.log
